//--- bench/mem_stage_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_asserts
	import mem_stage_pkg::*;
	import dcache_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_rst_n,
	input wire logic [TAG_BITS-1:0] i_tag,
	input wire mem_op_e i_op,
	input wire logic [TAG_BITS-1:0] i_out_tag,
	input wire logic i_busy,
	input wire logic i_bus_request,
	input wire logic i_bus_rw,
	input wire logic [31:0] i_bus_address,
	input wire logic [31:0] i_bus_wdata,
	input wire logic i_bus_ready,
	input wire logic i_cache_request,
	input wire cache_cmd_e i_cache_cmd
);

	int error_count = 0;

	// a pending bus access keeps its fields until the ready pulse.
	bus_hold: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_bus_request && !i_bus_ready) |=> (i_bus_request && $stable(i_bus_rw)
			&& $stable(i_bus_address) && $stable(i_bus_wdata)))
		else begin
			$error("bus request or its fields changed before ready");
			error_count++;
		end

	bus_drop: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_bus_request && i_bus_ready) |=> !i_bus_request)
		else begin
			$error("bus request still high after the ready cycle");
			error_count++;
		end

	bus_reset: assert property (@(posedge i_clock) !i_rst_n |=> !i_bus_request)
		else begin
			$error("bus request high after reset");
			error_count++;
		end

	busy_idle: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_tag == i_out_tag) |-> !i_busy)
		else begin
			$error("busy while the tags match");
			error_count++;
		end

	// a memory operation stalls the pipeline until it retires.
	busy_pending: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		((i_tag != i_out_tag) && (i_op != OP_NONE)) |-> i_busy)
		else begin
			$error("not busy while a memory operation is pending");
			error_count++;
		end

	// the flush walk is the one cache command that runs without the bus.
	cache_wait: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_cache_request && !i_bus_request && i_cache_cmd != CMD_FLUSH)
			|=> (i_bus_request || !i_cache_request))
		else begin
			$error("cache request waited without a bus access");
			error_count++;
		end

endmodule

`default_nettype wire

//--- bench/mem_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_tb
	import mem_stage_pkg::*;
	import dcache_pkg::*;
();

	localparam int WAIT_LIMIT = 200;

	logic i_clock = 1'b0;
	logic i_rst_n;
	logic [TAG_BITS-1:0] i_tag;
	mem_op_e i_op;
	mem_width_e i_width;
	logic i_signed;
	logic [31:0] i_address;
	logic [31:0] i_wdata;
	logic [REG_BITS-1:0] i_inst_rd;
	logic [REG_BITS-1:0] i_mem_inst_rd;
	logic o_busy;
	logic [TAG_BITS-1:0] o_tag;
	logic [31:0] o_rd;
	logic [REG_BITS-1:0] o_inst_rd;
	logic o_bus_request;
	logic o_bus_rw;
	logic [31:0] o_bus_address;
	logic [31:0] o_bus_wdata;
	logic i_bus_ready;
	logic [31:0] i_bus_rdata;

	integer seed = 32'hcc3c;
	int bus_wait = -1;
	int bus_reads;
	logic [31:0] bus_mem [logic [31:0]]; // word address to data.
	logic [31:0] ref_mem [logic [31:0]];

	always #5 i_clock = ~i_clock;

	mem_stage #(.DCACHE_LINES(8)) i_dut (.*);

	bind mem_stage mem_stage_asserts u_asserts (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_tag(i_tag),
		.i_op(i_op),
		.i_out_tag(o_tag),
		.i_busy(o_busy),
		.i_bus_request(o_bus_request),
		.i_bus_rw(o_bus_rw),
		.i_bus_address(o_bus_address),
		.i_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready),
		.i_cache_request(cache_request),
		.i_cache_cmd(cache_cmd)
	);

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9; // untouched words differ everywhere.
	endfunction

	function automatic logic [31:0] bus_peek(input logic [31:0] addr);
		return bus_mem.exists(addr) ? bus_mem[addr] : fill_word(addr);
	endfunction

	function automatic logic [31:0] ref_peek(input logic [31:0] addr);
		logic [31:0] key;
		key = {addr[31:2], 2'b00};
		return ref_mem.exists(key) ? ref_mem[key] : fill_word(key);
	endfunction

	function automatic logic [31:0] store_merge(input logic [31:0] old_word,
			input mem_width_e width, input logic [1:0] idx, input logic [31:0] data);
		logic [31:0] result;
		result = old_word;
		if (width == WIDTH_WORD)
			result = data;
		else if (width == WIDTH_HALF)
			result[(idx[1] ? 16 : 0) +: 16] = data[15:0];
		else
			result[int'(idx) * 8 +: 8] = data[7:0];
		return result;
	endfunction

	function automatic logic [31:0] load_extract(input logic [31:0] word,
			input mem_width_e width, input logic [1:0] idx, input logic sgn);
		logic [7:0] lane_byte;
		logic [15:0] lane_half;
		lane_byte = word[int'(idx) * 8 +: 8];
		lane_half = idx[1] ? word[31:16] : word[15:0];
		if (width == WIDTH_WORD)
			return word;
		if (width == WIDTH_HALF)
			return (sgn && lane_half[15]) ? {16'hffff, lane_half} : {16'h0000, lane_half};
		return (sgn && lane_byte[7]) ? {24'hff_ffff, lane_byte} : {24'h00_0000, lane_byte};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			$display("ERR %s: got %h expected %h", name, got, expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// a failed protocol assertion ends the run at the next edge.
	always @(posedge i_clock) begin
		if (i_dut.u_asserts.error_count != 0) begin
			$display("a protocol assertion in the bound checker failed");
			$display("Test failed");
			$fatal(1);
		end
	end

	// answers each bus request after 1 to 4 cycles.
	always @(posedge i_clock) begin
		#1;
		if (i_bus_ready) begin
			i_bus_ready = 1'b0;
		end else if (o_bus_request) begin
			if (bus_wait < 0)
				bus_wait = $unsigned($random(seed)) % 4;
			if (bus_wait == 0) begin
				if (o_bus_rw) begin
					bus_mem[o_bus_address] = o_bus_wdata;
				end else begin
					i_bus_rdata = bus_peek(o_bus_address);
					bus_reads++;
				end
				i_bus_ready = 1'b1;
			end
			bus_wait--;
		end
	end

	task automatic run_op(input mem_op_e op, input mem_width_e width, input logic sgn,
			input logic [31:0] addr, input logic [31:0] data);
		int cycles;
		@(posedge i_clock);
		#1;
		i_op = op;
		i_width = width;
		i_signed = sgn;
		i_address = addr;
		i_wdata = data;
		i_inst_rd = REG_BITS'($random(seed));
		i_mem_inst_rd = ~i_inst_rd;
		i_tag = i_tag + 1'b1; // a new tag starts the operation.
		cycles = 0;
		while (o_tag != i_tag) begin
			@(posedge i_clock);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("timeout: operation with tag %0h never retired", i_tag);
				$display("Test failed");
				$fatal(1);
			end
		end
	endtask

	task automatic write_access(input logic [31:0] addr, input mem_width_e width,
			input logic [31:0] data);
		ref_mem[{addr[31:2], 2'b00}] = store_merge(ref_peek(addr), width, addr[1:0], data);
		run_op(OP_WRITE, width, 1'b0, addr, data);
		check_value("o_rd", o_rd, data);
		check_value("o_inst_rd", o_inst_rd, i_inst_rd);
	endtask

	task automatic read_access(input logic [31:0] addr, input mem_width_e width,
			input logic sgn);
		logic [31:0] expected;
		expected = load_extract(ref_peek(addr), width, addr[1:0], sgn);
		run_op(OP_READ, width, sgn, addr, $random(seed));
		check_value("o_rd", o_rd, expected);
		check_value("o_inst_rd", o_inst_rd, i_mem_inst_rd);
	endtask

	task automatic other_op(input mem_op_e op);
		logic [31:0] data;
		data = $random(seed);
		run_op(op, WIDTH_WORD, 1'b0, 32'h0, data);
		check_value("o_rd", o_rd, data);
		check_value("o_inst_rd", o_inst_rd, i_inst_rd);
	endtask

	initial begin
		logic [31:0] word_base [2];
		logic [31:0] data;
		int reads_before;
		i_rst_n = 1'b0;
		i_tag = '0;
		i_op = OP_NONE;
		i_width = WIDTH_WORD;
		i_signed = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_inst_rd = '0;
		i_mem_inst_rd = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		bus_reads = 0;
		word_base[0] = 32'h1000_0040;
		word_base[1] = {CACHEABLE_REGION, 28'h000_0080};
		repeat (5) @(posedge i_clock);
		#1 i_rst_n = 1'b1;

		repeat (4) other_op(OP_NONE);

		for (int b = 0; b < 2; b++) begin
			data = $random(seed);
			write_access(word_base[b], WIDTH_WORD, data);
			read_access(word_base[b], WIDTH_WORD, 1'b0);
			check_value("bus_mem", bus_peek(word_base[b]), data); // write-through reached the bus.

			for (int idx = 0; idx < 4; idx++) begin
				write_access(word_base[b] + 32'h40 + idx, WIDTH_BYTE, $random(seed));
				read_access(word_base[b] + 32'h40, WIDTH_WORD, 1'b0);
			end
			for (int idx = 0; idx < 4; idx += 2) begin
				write_access(word_base[b] + 32'h40 + idx, WIDTH_HALF, $random(seed));
				read_access(word_base[b] + 32'h40, WIDTH_WORD, 1'b0);
			end

			// every byte and half of this word has its top bit set.
			write_access(word_base[b] + 32'h80, WIDTH_WORD, 32'hc3b4_a596);
			for (int sgn = 0; sgn < 2; sgn++) begin
				for (int idx = 0; idx < 4; idx++) begin
					read_access(word_base[b] + 32'h80 + idx, WIDTH_BYTE, sgn[0]);
					read_access(word_base[b] + 32'h80 + idx, WIDTH_HALF, sgn[0]);
				end
			end
		end

		reads_before = bus_reads;
		read_access({CACHEABLE_REGION, 28'h000_0200}, WIDTH_WORD, 1'b0);
		read_access({CACHEABLE_REGION, 28'h000_0200}, WIDTH_WORD, 1'b0);
		check_value("bus_reads", bus_reads, reads_before + 1);
		other_op(OP_FLUSH);
		read_access({CACHEABLE_REGION, 28'h000_0200}, WIDTH_WORD, 1'b0);
		check_value("bus_reads", bus_reads, reads_before + 2);

		reads_before = bus_reads;
		read_access(32'h3000_0200, WIDTH_WORD, 1'b0);
		read_access(32'h3000_0200, WIDTH_WORD, 1'b0);
		check_value("bus_reads", bus_reads, reads_before + 2);

		if (i_dut.u_asserts.error_count == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("a protocol assertion in the bound checker failed");
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- mem_stage.f
source/mem_stage_pkg.sv
source/dcache_pkg.sv
source/lane_align.sv
source/dcache.sv
source/mem_stage_ctrl.sv
source/mem_stage.sv
bench/mem_stage_asserts.sv
bench/mem_stage_tb.sv

//--- source/dcache.sv
`timescale 1ns/1ns
`default_nettype none

module dcache
	import dcache_pkg::*;
#(
	parameter int DCACHE_LINES = 16
)(
	input wire logic i_clock,
	input wire logic i_rst_n,

	input wire logic i_request,
	input wire cache_cmd_e i_cmd,
	input wire logic [31:0] i_address,
	input wire logic [31:0] i_wdata,
	output logic o_ready,
	output logic [31:0] o_rdata,

	output logic o_bus_request,
	output logic o_bus_rw,
	output logic [31:0] o_bus_address,
	output logic [31:0] o_bus_wdata,
	input wire logic i_bus_ready,
	input wire logic [31:0] i_bus_rdata
);

	localparam int INDEX_BITS = $clog2(DCACHE_LINES);
	localparam int LINE_TAG_BITS = 30 - INDEX_BITS;

	typedef enum logic [1:0] {
		C_IDLE,
		C_BUS,
		C_FLUSH
	} dcache_state_e;

	dcache_state_e state;

	logic [31:0] line_data [DCACHE_LINES];
	logic [LINE_TAG_BITS-1:0] line_tag [DCACHE_LINES];
	logic [DCACHE_LINES-1:0] line_valid;
	logic [INDEX_BITS:0] flush_count; // top bit set once every line is cleared.

	logic [INDEX_BITS-1:0] req_index;
	logic [LINE_TAG_BITS-1:0] req_tag;
	logic req_cacheable;
	logic req_hit;
	logic [INDEX_BITS-1:0] bus_index;
	logic [LINE_TAG_BITS-1:0] bus_tag;
	logic bus_cacheable;
	logic bus_hit;
	logic bus_issue;

	assign req_index = i_address[INDEX_BITS+1:2];
	assign req_tag = i_address[31:INDEX_BITS+2];
	assign req_cacheable = (i_address[31:28] == CACHEABLE_REGION);
	assign req_hit = req_cacheable && line_valid[req_index] && (line_tag[req_index] == req_tag);

	// the latched bus address selects the line when the access ends.
	assign bus_index = o_bus_address[INDEX_BITS+1:2];
	assign bus_tag = o_bus_address[31:INDEX_BITS+2];
	assign bus_cacheable = (o_bus_address[31:28] == CACHEABLE_REGION);
	assign bus_hit = bus_cacheable && line_valid[bus_index] && (line_tag[bus_index] == bus_tag);

	assign bus_issue = (state == C_IDLE) && i_request &&
		((i_cmd == CMD_WRITE) || ((i_cmd == CMD_READ) && !req_hit));

	always_comb begin
		o_ready = 1'b0;
		o_rdata = line_data[req_index];
		case (state)
			C_IDLE: o_ready = i_request && (i_cmd == CMD_READ) && req_hit;
			C_BUS: begin
				o_ready = i_bus_ready;
				o_rdata = i_bus_rdata; // fill data goes straight back to the stage.
			end
			C_FLUSH: o_ready = flush_count[INDEX_BITS];
			default: o_ready = 1'b0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= C_IDLE;
			o_bus_request <= 1'b0;
			line_valid <= '0;
			flush_count <= '0;
		end else begin
			case (state)
				C_IDLE: begin
					if (bus_issue) begin
						o_bus_request <= 1'b1;
						state <= C_BUS;
					end else if (i_request && i_cmd == CMD_FLUSH) begin
						flush_count <= '0;
						state <= C_FLUSH;
					end
				end

				C_BUS: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						if (!o_bus_rw && bus_cacheable)
							line_valid[bus_index] <= 1'b1;
						state <= C_IDLE;
					end
				end

				C_FLUSH: begin
					if (flush_count[INDEX_BITS]) begin
						state <= C_IDLE;
					end else begin
						line_valid[flush_count[INDEX_BITS-1:0]] <= 1'b0;
						flush_count <= flush_count + 1'b1;
					end
				end

				default: state <= C_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (bus_issue) begin
			o_bus_rw <= (i_cmd == CMD_WRITE);
			o_bus_address <= i_address;
			o_bus_wdata <= i_wdata;
		end

		if (state == C_BUS && i_bus_ready && bus_cacheable) begin
			if (!o_bus_rw) begin
				line_data[bus_index] <= i_bus_rdata;
				line_tag[bus_index] <= bus_tag;
			end else if (bus_hit) begin
				line_data[bus_index] <= o_bus_wdata; // write-through keeps a present line current.
			end
		end
	end

endmodule

`default_nettype wire

//--- source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// value of address bits 31:28 that selects the cached region.
	localparam logic [3:0] CACHEABLE_REGION = 4'h2;

	typedef enum logic [1:0] {
		CMD_READ,
		CMD_WRITE,
		CMD_FLUSH
	} cache_cmd_e;

endpackage

`default_nettype wire

//--- source/lane_align.sv
`timescale 1ns/1ns
`default_nettype none

module lane_align
	import mem_stage_pkg::*;
(
	input wire mem_width_e i_width,
	input wire logic i_signed,
	input wire logic [1:0] i_byte_index,
	input wire logic [31:0] i_read_word,
	input wire logic [31:0] i_rmw_word,
	input wire logic [31:0] i_store_data,
	output logic [31:0] o_load_value,
	output logic [31:0] o_merged_word
);

	logic [31:0] shifted_word;
	logic [7:0] load_byte;
	logic [15:0] load_half;

	assign shifted_word = i_read_word >> {i_byte_index, 3'b000};
	assign load_byte = shifted_word[7:0];
	assign load_half = i_byte_index[1] ? i_read_word[31:16] : i_read_word[15:0]; // bit 0 ignored.

	always_comb begin
		case (i_width)
			WIDTH_BYTE: o_load_value = {{24{i_signed & load_byte[7]}}, load_byte};
			WIDTH_HALF: o_load_value = {{16{i_signed & load_half[15]}}, load_half};
			default: o_load_value = i_read_word;
		endcase
	end

	// Only the addressed lanes take the store data.
	always_comb begin
		o_merged_word = i_rmw_word;
		case (i_width)
			WIDTH_BYTE: begin
				case (i_byte_index)
					2'd0: o_merged_word[7:0] = i_store_data[7:0];
					2'd1: o_merged_word[15:8] = i_store_data[7:0];
					2'd2: o_merged_word[23:16] = i_store_data[7:0];
					default: o_merged_word[31:24] = i_store_data[7:0];
				endcase
			end
			WIDTH_HALF: begin
				if (i_byte_index[1])
					o_merged_word[31:16] = i_store_data[15:0];
				else
					o_merged_word[15:0] = i_store_data[15:0];
			end
			default: o_merged_word = i_store_data;
		endcase
	end

endmodule

`default_nettype wire

//--- source/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage
	import mem_stage_pkg::*;
	import dcache_pkg::*;
#(
	parameter int DCACHE_LINES = 16
)(
	input wire logic i_clock,
	input wire logic i_rst_n,

	input wire logic [TAG_BITS-1:0] i_tag,
	input wire mem_op_e i_op,
	input wire mem_width_e i_width,
	input wire logic i_signed,
	input wire logic [31:0] i_address,
	input wire logic [31:0] i_wdata,
	input wire logic [REG_BITS-1:0] i_inst_rd,
	input wire logic [REG_BITS-1:0] i_mem_inst_rd,

	output logic o_busy,
	output logic [TAG_BITS-1:0] o_tag,
	output logic [31:0] o_rd,
	output logic [REG_BITS-1:0] o_inst_rd,

	output logic o_bus_request,
	output logic o_bus_rw,
	output logic [31:0] o_bus_address,
	output logic [31:0] o_bus_wdata,
	input wire logic i_bus_ready,
	input wire logic [31:0] i_bus_rdata
);

	logic cache_request;
	cache_cmd_e cache_cmd;
	logic [31:0] cache_address;
	logic [31:0] cache_wdata;
	logic cache_ready;
	logic [31:0] cache_rdata;
	logic [31:0] load_value;
	logic [31:0] merged_word;
	logic [31:0] rmw_word;

	mem_stage_ctrl u_ctrl (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_tag(i_tag),
		.i_op(i_op),
		.i_width(i_width),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_inst_rd(i_inst_rd),
		.i_mem_inst_rd(i_mem_inst_rd),
		.o_busy(o_busy),
		.o_tag(o_tag),
		.o_rd(o_rd),
		.o_inst_rd(o_inst_rd),
		.o_cache_request(cache_request),
		.o_cache_cmd(cache_cmd),
		.o_cache_address(cache_address),
		.o_cache_wdata(cache_wdata),
		.i_cache_ready(cache_ready),
		.i_cache_rdata(cache_rdata),
		.i_load_value(load_value),
		.i_merged_word(merged_word),
		.o_rmw_word(rmw_word)
	);

	lane_align u_lane_align (
		.i_width(i_width),
		.i_signed(i_signed),
		.i_byte_index(i_address[1:0]),
		.i_read_word(cache_rdata),
		.i_rmw_word(rmw_word),
		.i_store_data(i_wdata),
		.o_load_value(load_value),
		.o_merged_word(merged_word)
	);

	dcache #(
		.DCACHE_LINES(DCACHE_LINES)
	) u_dcache (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(cache_request),
		.i_cmd(cache_cmd),
		.i_address(cache_address),
		.i_wdata(cache_wdata),
		.o_ready(cache_ready),
		.o_rdata(cache_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address),
		.o_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule

`default_nettype wire

//--- source/mem_stage_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_ctrl
	import mem_stage_pkg::*;
	import dcache_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_rst_n,

	input wire logic [TAG_BITS-1:0] i_tag,
	input wire mem_op_e i_op,
	input wire mem_width_e i_width,
	input wire logic [31:0] i_address,
	input wire logic [31:0] i_wdata,
	input wire logic [REG_BITS-1:0] i_inst_rd,
	input wire logic [REG_BITS-1:0] i_mem_inst_rd,

	output logic o_busy,
	output logic [TAG_BITS-1:0] o_tag,
	output logic [31:0] o_rd,
	output logic [REG_BITS-1:0] o_inst_rd,

	output logic o_cache_request,
	output cache_cmd_e o_cache_cmd,
	output logic [31:0] o_cache_address,
	output logic [31:0] o_cache_wdata,
	input wire logic i_cache_ready,
	input wire logic [31:0] i_cache_rdata,

	input wire logic [31:0] i_load_value,
	input wire logic [31:0] i_merged_word,
	output logic [31:0] o_rmw_word
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_READ,
		S_WRITE,
		S_RMW_READ,
		S_RMW_MERGE,
		S_RMW_WRITE,
		S_FLUSH
	} ctrl_state_e;

	ctrl_state_e state;
	logic new_op;

	assign new_op = (i_tag != o_tag);

	// pass-through never stalls the pipeline.
	assign o_busy = new_op && (i_op != OP_NONE);

	assign o_cache_address = {i_address[31:2], 2'b00}; // the cache only sees whole words.

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= S_IDLE;
			o_cache_request <= 1'b0;
			o_cache_cmd <= CMD_READ;
			o_tag <= '0;
			o_rd <= '0;
			o_inst_rd <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (new_op) begin
						case (i_op)
							OP_READ: begin
								o_cache_request <= 1'b1;
								o_cache_cmd <= CMD_READ;
								state <= S_READ;
							end
							OP_WRITE: begin
								o_cache_request <= 1'b1;
								if (i_width == WIDTH_WORD) begin
									o_cache_cmd <= CMD_WRITE;
									state <= S_WRITE;
								end else begin
									// narrow store fetches the word first.
									o_cache_cmd <= CMD_READ;
									state <= S_RMW_READ;
								end
							end
							OP_FLUSH: begin
								o_cache_request <= 1'b1;
								o_cache_cmd <= CMD_FLUSH;
								state <= S_FLUSH;
							end
							default: begin
								o_tag <= i_tag;
								o_rd <= i_wdata;
								o_inst_rd <= i_inst_rd;
							end
						endcase
					end
				end

				S_READ: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						o_tag <= i_tag;
						o_rd <= i_load_value;
						o_inst_rd <= i_mem_inst_rd;
						state <= S_IDLE;
					end
				end

				S_RMW_READ: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						state <= S_RMW_MERGE;
					end
				end

				S_RMW_MERGE: begin
					o_cache_request <= 1'b1; // merged word is latched in this cycle.
					o_cache_cmd <= CMD_WRITE;
					state <= S_RMW_WRITE;
				end

				S_WRITE, S_RMW_WRITE, S_FLUSH: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						o_tag <= i_tag;
						o_rd <= i_wdata;
						o_inst_rd <= i_inst_rd;
						state <= S_IDLE;
					end
				end

				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == S_IDLE)
			o_cache_wdata <= i_wdata;
		else if (state == S_RMW_MERGE)
			o_cache_wdata <= i_merged_word;

		if (state == S_RMW_READ && i_cache_ready)
			o_rmw_word <= i_cache_rdata; // old word kept for the merge.
	end

endmodule

`default_nettype wire

//--- source/mem_stage_pkg.sv
`default_nettype none

// types shared by the execute side and the memory stage.
package mem_stage_pkg;

	localparam int TAG_BITS = 4;
	localparam int REG_BITS = 5;

	typedef enum logic [1:0] {
		OP_NONE,
		OP_READ,
		OP_WRITE,
		OP_FLUSH
	} mem_op_e;

	typedef enum logic [1:0] {
		WIDTH_BYTE,
		WIDTH_HALF,
		WIDTH_WORD
	} mem_width_e;

endpackage

`default_nettype wire
